//--- logic/ifu_align_pkg.sv
/*
 * instruction aligner shared definitions
 * widths, slot occupancy encoding and queue pointer types
 */
package ifu_align_pkg;

   localparam int FETCH_BITS  = 32;   // fetch word, also a full instruction
   localparam int HALF_BITS   = 16;   // one parcel, also a compressed instruction
   localparam int QUEUE_SLOTS = 3;

   // halfword valids of a slot, right justified
   typedef enum logic [1:0] {
      SLOT_EMPTY = 2'b00,
      SLOT_LOW   = 2'b01,   // one halfword left
      SLOT_FULL  = 2'b11
   } slot_state_e;

   typedef logic [1:0] qptr_t;       // ring index, 0 to 2
   typedef logic [1:0] hw_flags_t;   // bit 0 is the lower halfword

endpackage

//--- logic/align_slot_ctl.sv
/*
 * aligner slot control
 * packs fetches toward f0, shifts on decode, owns the error stall
 */
`timescale 1ns/1ps

module align_slot_ctl (
   input  logic                       clk,
   input  logic                       reset,
   input  ifu_align_pkg::hw_flags_t   fetch_val,
   input  logic                       flush,
   input  logic                       decode,
   input  logic                       async_error_start,
   input  logic                       i0_pc4,
   output ifu_align_pkg::slot_state_e f0_state,
   output ifu_align_pkg::slot_state_e f1_state,
   output logic                       consume1,
   output logic                       consume2,
   output logic                       f0_shift_2b,
   output logic                       f1_shift_2b,
   output logic                       instr_aligned
);

   ifu_align_pkg::slot_state_e f0_q, f1_q, f2_q;
   ifu_align_pkg::slot_state_e sf0, sf1;          // after this cycle's shift
   ifu_align_pkg::slot_state_e f0_nxt, f1_nxt, f2_nxt;
   ifu_align_pkg::slot_state_e fetch_st;
   logic                       error_stall;
   logic                       i0_shift, shift_2b, shift_4b;
   logic                       consume_f0, consume_f1;

   //************************************************************
   // shift amount from decode
   //************************************************************
   assign i0_shift      = decode & ~error_stall;
   assign instr_aligned = i0_shift;
   assign shift_2b      = i0_shift & ~i0_pc4;
   assign shift_4b      = i0_shift &  i0_pc4;

   // f0 low slot with a 4B instruction borrows f1's lower half
   assign f0_shift_2b = (shift_2b & f0_q[0]) | (shift_4b & f0_q[0] & ~f0_q[1]);
   assign f1_shift_2b = shift_4b & f0_q[0] & ~f0_q[1];

   always_comb begin
      if (shift_2b)
         sf0 = ifu_align_pkg::slot_state_e'({1'b0, f0_q[1]});
      else if (shift_4b)
         sf0 = ifu_align_pkg::SLOT_EMPTY;
      else
         sf0 = f0_q;
      sf1 = f1_shift_2b ? ifu_align_pkg::slot_state_e'({1'b0, f1_q[1]}) : f1_q;
   end

   // whole entries drained this cycle, to fetch control
   assign consume_f0 = f0_q[0] & ~sf0[0];
   assign consume_f1 = f1_q[0] & ~sf1[0];
   assign consume1   = consume_f0 & ~consume_f1 & ~flush;
   assign consume2   = consume_f0 &  consume_f1 & ~flush;

   //************************************************************
   // occupancy table, {sf0, sf1, f2}
   //************************************************************
   assign fetch_st = fetch_val[0] ? ifu_align_pkg::slot_state_e'(fetch_val)
                                  : ifu_align_pkg::SLOT_EMPTY;

   always_comb begin
      f0_nxt = sf0;
      f1_nxt = sf1;
      f2_nxt = f2_q;
      case ({sf0[0], sf1[0], f2_q[0]})
         3'b000: f0_nxt = fetch_st;
         3'b100: f1_nxt = fetch_st;
         3'b110: f2_nxt = fetch_st;
         3'b010: begin
            f0_nxt = sf1;
            f1_nxt = fetch_st;
         end
         3'b001: begin
            f0_nxt = f2_q;
            f1_nxt = fetch_st;
            f2_nxt = ifu_align_pkg::SLOT_EMPTY;
         end
         3'b011: begin
            f0_nxt = sf1;
            f1_nxt = f2_q;
            f2_nxt = fetch_st;
         end
         default: ;   // 111 holds, 101 never occurs
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         f0_q <= ifu_align_pkg::SLOT_EMPTY;
         f1_q <= ifu_align_pkg::SLOT_EMPTY;
         f2_q <= ifu_align_pkg::SLOT_EMPTY;
      end else begin
         f0_q <= f0_nxt;
         f1_q <= f1_nxt;
         f2_q <= f2_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         error_stall <= 1'b0;
      else
         error_stall <= (error_stall | async_error_start) & ~flush;   // held until flush
   end

   assign f0_state = f0_q;
   assign f1_state = f1_q;

   a_one_consume: assert property (@(posedge clk) disable iff (reset)
      !(consume1 && consume2));

   // slots stay packed toward f0
   a_packed: assert property (@(posedge clk) disable iff (reset)
      !(f0_q == ifu_align_pkg::SLOT_EMPTY && f1_q != ifu_align_pkg::SLOT_EMPTY));

   // fetch control must track the consume reports
   a_no_overrun: assert property (@(posedge clk) disable iff (reset)
      (fetch_val[0] && !flush) |-> !(sf0[0] && sf1[0] && f2_q[0]));

endmodule

//--- logic/fetch_queue_ptr.sv
/*
 * fetch queue pointers
 * modulo-3 write and read counters plus per-entry halfword offsets
 */
`timescale 1ns/1ps

module fetch_queue_ptr (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 fetch_valid,
   input  logic                 flush,
   input  logic                 consume1,
   input  logic                 consume2,
   input  logic                 f0_shift_2b,
   input  logic                 f1_shift_2b,
   output logic [2:0]           write_en,
   output ifu_align_pkg::qptr_t read_ptr,
   output logic                 q0_upper,
   output logic                 q1_upper
);

   ifu_align_pkg::qptr_t wr_q;
   ifu_align_pkg::qptr_t rd_plus1, rd_plus2, wr_plus1;
   logic [2:0]           off_q;   // lower half of entry already used

   assign rd_plus1 = (read_ptr == 2'd2) ? 2'd0 : read_ptr + 2'd1;
   assign rd_plus2 = (read_ptr == 2'd0) ? 2'd2 : read_ptr - 2'd1;
   assign wr_plus1 = (wr_q == 2'd2) ? 2'd0 : wr_q + 2'd1;

   assign write_en = {3{fetch_valid & ~flush}} & {wr_q == 2'd2, wr_q == 2'd1, wr_q == 2'd0};

   //************************************************************
   // ring pointers
   //************************************************************
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         wr_q     <= 2'd0;
         read_ptr <= 2'd0;
      end else begin
         if (fetch_valid)
            wr_q <= wr_plus1;
         if (consume2)
            read_ptr <= rd_plus2;
         else if (consume1)
            read_ptr <= rd_plus1;
      end
   end

   // offsets follow the slot the entry sits in
   always_ff @(posedge clk) begin
      if (reset) begin
         off_q <= '0;
      end else begin
         for (int i = 0; i < ifu_align_pkg::QUEUE_SLOTS; i++) begin
            if (write_en[i])
               off_q[i] <= 1'b0;   // fresh fetch
            else if (read_ptr == ifu_align_pkg::qptr_t'(i))
               off_q[i] <= off_q[i] | f0_shift_2b;
            else if (rd_plus1 == ifu_align_pkg::qptr_t'(i))
               off_q[i] <= off_q[i] | f1_shift_2b;
         end
      end
   end

   assign q0_upper = off_q[read_ptr];
   assign q1_upper = off_q[rd_plus1];

   a_ptr_range: assert property (@(posedge clk) disable iff (reset)
      (wr_q != 2'd3) && (read_ptr != 2'd3));

endmodule

//--- logic/fetch_queue_store.sv
/*
 * fetch queue storage
 * three fetch entries, rotated and halfword-aligned read of f0 and f1
 */
`timescale 1ns/1ps

module fetch_queue_store #(
   parameter int PC_MSB = 31
) (
   input  logic                                  clk,
   input  logic [ifu_align_pkg::FETCH_BITS-1:0]  fetch_data,
   input  logic [PC_MSB:1]                       fetch_pc,
   input  ifu_align_pkg::hw_flags_t              access_fault,
   input  logic [1:0]                            access_fault_type,
   input  ifu_align_pkg::hw_flags_t              ecc_double_err,
   input  logic [2:0]                            write_en,
   input  ifu_align_pkg::qptr_t                  read_ptr,
   input  logic                                  q0_upper,
   input  logic                                  q1_upper,
   output logic [ifu_align_pkg::FETCH_BITS-1:0]  f0_data,
   output logic [ifu_align_pkg::HALF_BITS-1:0]   f1_half,
   output logic [PC_MSB:1]                       f0_pc,
   output logic [PC_MSB:1]                       f1_pc,
   output ifu_align_pkg::hw_flags_t              f0_icaf,
   output ifu_align_pkg::hw_flags_t              f0_dbecc,
   output ifu_align_pkg::hw_flags_t              f1_icaf,
   output ifu_align_pkg::hw_flags_t              f1_dbecc,
   output logic [1:0]                            f0_icaf_type,
   output logic [1:0]                            f1_icaf_type
);

   localparam int FB = ifu_align_pkg::FETCH_BITS;
   localparam int HB = ifu_align_pkg::HALF_BITS;

   logic [FB-1:0]            data_q  [ifu_align_pkg::QUEUE_SLOTS];
   logic [PC_MSB:1]          pc_q    [ifu_align_pkg::QUEUE_SLOTS];
   ifu_align_pkg::hw_flags_t icaf_q  [ifu_align_pkg::QUEUE_SLOTS];
   ifu_align_pkg::hw_flags_t dbecc_q [ifu_align_pkg::QUEUE_SLOTS];
   logic [1:0]               type_q  [ifu_align_pkg::QUEUE_SLOTS];
   ifu_align_pkg::qptr_t     e0, e1;
   logic [FB-1:0]            d0, d1;

   //************************************************************
   // entry write
   //************************************************************
   always_ff @(posedge clk) begin
      for (int i = 0; i < ifu_align_pkg::QUEUE_SLOTS; i++) begin
         if (write_en[i]) begin
            data_q[i]  <= fetch_data;
            pc_q[i]    <= fetch_pc;
            icaf_q[i]  <= access_fault;
            dbecc_q[i] <= ecc_double_err;
            type_q[i]  <= access_fault_type;
         end
      end
   end

   // rotate so f0 is the oldest entry
   assign e0 = read_ptr;
   assign e1 = (read_ptr == 2'd2) ? 2'd0 : read_ptr + 2'd1;
   assign d0 = data_q[e0];
   assign d1 = data_q[e1];

   assign f0_data = q0_upper ? {{HB{1'b0}}, d0[FB-1:HB]} : d0;
   assign f1_half = q1_upper ? d1[FB-1:HB] : d1[HB-1:0];

   assign f0_pc = pc_q[e0] + {{(PC_MSB-1){1'b0}}, q0_upper};   // one halfword on
   assign f1_pc = pc_q[e1];

   assign f0_icaf  = q0_upper ? {1'b0, icaf_q[e0][1]}  : icaf_q[e0];
   assign f0_dbecc = q0_upper ? {1'b0, dbecc_q[e0][1]} : dbecc_q[e0];
   assign f1_icaf  = q1_upper ? {1'b0, icaf_q[e1][1]}  : icaf_q[e1];
   assign f1_dbecc = q1_upper ? {1'b0, dbecc_q[e1][1]} : dbecc_q[e1];

   assign f0_icaf_type = type_q[e0];   // one type per fetch
   assign f1_icaf_type = type_q[e1];

endmodule

//--- logic/instr_align_out.sv
/*
 * instruction 0 builder
 * joins f0 and f1 halfwords, sizes the instruction and merges faults
 */
`timescale 1ns/1ps

module instr_align_out #(
   parameter int PC_MSB = 31
) (
   input  ifu_align_pkg::slot_state_e            f0_state,
   input  ifu_align_pkg::slot_state_e            f1_state,
   input  logic [ifu_align_pkg::FETCH_BITS-1:0]  f0_data,
   input  logic [ifu_align_pkg::HALF_BITS-1:0]   f1_half,
   input  logic [PC_MSB:1]                       f0_pc,
   input  ifu_align_pkg::hw_flags_t              f0_icaf,
   input  ifu_align_pkg::hw_flags_t              f0_dbecc,
   input  ifu_align_pkg::hw_flags_t              f1_icaf,
   input  ifu_align_pkg::hw_flags_t              f1_dbecc,
   input  logic [1:0]                            f0_icaf_type,
   input  logic [1:0]                            f1_icaf_type,
   output logic                                  i0_valid,
   output logic [ifu_align_pkg::FETCH_BITS-1:0]  i0_instr,
   output logic [ifu_align_pkg::HALF_BITS-1:0]   i0_cinst,
   output logic [PC_MSB:1]                       i0_pc,
   output logic                                  i0_pc4,
   output logic                                  i0_icaf,
   output logic [1:0]                            i0_icaf_type,
   output logic                                  i0_icaf_second,
   output logic                                  i0_dbecc
);

   localparam int HB = ifu_align_pkg::HALF_BITS;

   logic                                 f0_full, f0_low;
   logic [ifu_align_pkg::FETCH_BITS-1:0] align_data;
   ifu_align_pkg::hw_flags_t             align_val, align_icaf, align_dbecc, fault_any;
   logic                                 first4b;

   assign f0_full = (f0_state == ifu_align_pkg::SLOT_FULL);
   assign f0_low  = (f0_state == ifu_align_pkg::SLOT_LOW);

   //************************************************************
   // halfword join, f1 fills the upper half when f0 is low
   //************************************************************
   always_comb begin
      align_data  = {f1_half, f0_data[HB-1:0]};
      align_val   = 2'b00;
      align_icaf  = 2'b00;
      align_dbecc = 2'b00;
      if (f0_full) begin
         align_data  = f0_data;
         align_val   = 2'b11;
         align_icaf  = f0_icaf;
         align_dbecc = f0_dbecc;
      end else if (f0_low) begin
         align_val   = {f1_state[0], 1'b1};
         align_icaf  = {f1_icaf[0], f0_icaf[0]};
         align_dbecc = {f1_dbecc[0], f0_dbecc[0]};
      end
   end

   assign first4b  = (align_data[1:0] == 2'b11);   // not compressed
   assign i0_valid = first4b ? align_val[1] : align_val[0];
   assign i0_pc4   = first4b;
   assign i0_pc    = f0_pc;
   assign i0_cinst = align_data[HB-1:0];
   assign i0_instr = first4b ? align_data : {{HB{1'b0}}, align_data[HB-1:0]};

   // a fault on any halfword faults the instruction
   assign i0_icaf  = first4b ? |align_icaf  : align_icaf[0];
   assign i0_dbecc = first4b ? |align_dbecc : align_dbecc[0];

   // type of the second fetch only when the fault lives there
   assign i0_icaf_type = (first4b & f0_low & ~align_icaf[0] & ~align_dbecc[0]) ?
                         f1_icaf_type : f0_icaf_type;

   assign fault_any      = align_icaf | align_dbecc;
   assign i0_icaf_second = first4b & ~fault_any[0] & fault_any[1];

endmodule

//--- logic/ifu_align_top.sv
/*
 * instruction aligner top
 * slot control, queue pointers, queue storage and instruction 0 output
 */
`timescale 1ns/1ps

module ifu_align_top #(
   parameter int PC_MSB = 31
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic [ifu_align_pkg::FETCH_BITS-1:0]  fetch_data,
   input  logic [PC_MSB:1]                       fetch_pc,
   input  ifu_align_pkg::hw_flags_t              fetch_val,
   input  ifu_align_pkg::hw_flags_t              access_fault,
   input  logic [1:0]                            access_fault_type,
   input  ifu_align_pkg::hw_flags_t              ecc_double_err,
   input  logic                                  decode,
   input  logic                                  flush,
   input  logic                                  async_error_start,
   output logic                                  i0_valid,
   output logic [ifu_align_pkg::FETCH_BITS-1:0]  i0_instr,
   output logic [ifu_align_pkg::HALF_BITS-1:0]   i0_cinst,
   output logic [PC_MSB:1]                       i0_pc,
   output logic                                  i0_pc4,
   output logic                                  i0_icaf,
   output logic [1:0]                            i0_icaf_type,
   output logic                                  i0_icaf_second,
   output logic                                  i0_dbecc,
   output logic                                  consume1,
   output logic                                  consume2,
   output logic                                  instr_aligned
);

   ifu_align_pkg::slot_state_e           f0_state, f1_state;
   ifu_align_pkg::qptr_t                 read_ptr;
   ifu_align_pkg::hw_flags_t             f0_icaf, f0_dbecc, f1_icaf, f1_dbecc;
   logic [ifu_align_pkg::FETCH_BITS-1:0] f0_data;
   logic [ifu_align_pkg::HALF_BITS-1:0]  f1_half;
   logic [PC_MSB:1]                      f0_pc;
   logic [1:0]                           f0_icaf_type, f1_icaf_type;
   logic [2:0]                           write_en;
   logic                                 f0_shift_2b, f1_shift_2b, q0_upper, q1_upper;

   align_slot_ctl i_slot_ctl (
      .clk, .reset, .fetch_val, .flush, .decode, .async_error_start, .i0_pc4,
      .f0_state, .f1_state, .consume1, .consume2, .f0_shift_2b, .f1_shift_2b,
      .instr_aligned
   );

   fetch_queue_ptr i_queue_ptr (
      .clk, .reset, .fetch_valid (fetch_val[0]), .flush, .consume1, .consume2,
      .f0_shift_2b, .f1_shift_2b, .write_en, .read_ptr, .q0_upper, .q1_upper
   );

   // f1 entry pc is not needed for instruction 0
   fetch_queue_store #(.PC_MSB(PC_MSB)) i_queue_store (
      .clk, .fetch_data, .fetch_pc, .access_fault, .access_fault_type, .ecc_double_err,
      .write_en, .read_ptr, .q0_upper, .q1_upper, .f0_data, .f1_half, .f0_pc,
      .f1_pc (), .f0_icaf, .f0_dbecc, .f1_icaf, .f1_dbecc, .f0_icaf_type, .f1_icaf_type
   );

   instr_align_out #(.PC_MSB(PC_MSB)) i_align_out (
      .f0_state, .f1_state, .f0_data, .f1_half, .f0_pc, .f0_icaf, .f0_dbecc,
      .f1_icaf, .f1_dbecc, .f0_icaf_type, .f1_icaf_type, .i0_valid, .i0_instr,
      .i0_cinst, .i0_pc, .i0_pc4, .i0_icaf, .i0_icaf_type, .i0_icaf_second, .i0_dbecc
   );

endmodule

//--- test/tb_ifu_align.sv
/*
 * instruction aligner testbench
 * directed fetches against a halfword reference queue, checked by assertions
 */
`timescale 1ns/1ps

module tb_ifu_align;

   localparam int PC_MSB   = 31;
   localparam int WAIT_MAX = 60;

   typedef struct packed {
      logic [15:0]     data;
      logic [PC_MSB:1] pc;
      logic            icaf;
      logic            dbecc;
      logic [1:0]      ftype;
      logic            last;    // final halfword of its fetch entry
   } half_t;

   logic clk, reset, decode, flush, async_error_start;
   logic [31:0]     fetch_data, i0_instr;
   logic [PC_MSB:1] fetch_pc, i0_pc, next_pc;
   logic [1:0]      fetch_val, access_fault, access_fault_type, ecc_double_err;
   logic            i0_valid, i0_pc4, i0_icaf, i0_icaf_second, i0_dbecc;
   logic [15:0]     i0_cinst;
   logic [1:0]      i0_icaf_type;
   logic            consume1, consume2, instr_aligned;

   half_t           hq[$];   // reference halfwords in fetch order
   logic            stall_m, retire, exp_c1, exp_c2;
   logic            exp_valid, exp_pc4, exp_icaf, exp_second, exp_dbecc;
   logic [31:0]     exp_instr;
   logic [PC_MSB:1] exp_pc;
   logic [1:0]      exp_type;
   int              occ, n_last, err_count, errs_at_start, hung;
   int              tests_passed, tests_failed;

   ifu_align_top i_ifu_align_top (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //************************************************************
   // reference model
   //************************************************************
   task automatic refresh_expected();
      half_t h0, h1;
      logic  wide;
      h0 = (hq.size() > 0) ? hq[0] : '0;
      h1 = (hq.size() > 1) ? hq[1] : '0;
      wide       = (h0.data[1:0] == 2'b11);   // not compressed
      exp_pc4    = wide;
      exp_valid  = wide ? (hq.size() > 1) : (hq.size() > 0);
      exp_instr  = wide ? {h1.data, h0.data} : {16'h0000, h0.data};
      exp_pc     = h0.pc;
      exp_icaf   = h0.icaf | (wide & h1.icaf);
      exp_dbecc  = h0.dbecc | (wide & h1.dbecc);
      exp_second = wide & ~(h0.icaf | h0.dbecc) & (h1.icaf | h1.dbecc);
      exp_type   = (wide && !(h0.icaf || h0.dbecc)) ? h1.ftype : h0.ftype;
      n_last     = int'(h0.last) + (wide ? int'(h1.last) : 0);
   endtask

   always_comb begin
      retire = decode & ~stall_m & exp_valid & ~flush;
      exp_c1 = retire && (n_last == 1);
      exp_c2 = retire && (n_last == 2);
   end

   always @(posedge clk) begin
      if (reset) begin
         hq.delete();
         stall_m = 1'b0;
         occ     = 0;
      end else begin
         if (retire) begin
            void'(hq.pop_front());
            if (exp_pc4)
               void'(hq.pop_front());
         end
         if (flush) begin
            hq.delete();
            occ = 0;
         end else begin
            // buffer occupancy as fetch control sees it
            occ = occ + int'(fetch_val[0]) - int'(consume1) - 2 * int'(consume2);
            if (fetch_val[0]) begin
               hq.push_back(half_t'({fetch_data[15:0], fetch_pc, access_fault[0],
                                     ecc_double_err[0], access_fault_type, ~fetch_val[1]}));
               if (fetch_val[1])
                  hq.push_back(half_t'({fetch_data[31:16], fetch_pc + PC_MSB'(1),
                                        access_fault[1], ecc_double_err[1],
                                        access_fault_type, 1'b1}));
            end
         end
         stall_m = (stall_m | async_error_start) & ~flush;
      end
      refresh_expected();
   end

   //************************************************************
   // checks
   //************************************************************
   task automatic report_mismatch(string name, logic [31:0] exp_v, logic [31:0] act_v);
      err_count++;
      $display("FAILED %0t %s expected %h actual %h", $time, name, exp_v, act_v);
   endtask

   a_valid: assert property (@(posedge clk) disable iff (reset) i0_valid == exp_valid)
      else report_mismatch("i0_valid", $sampled(exp_valid), $sampled(i0_valid));
   a_instr: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> i0_instr == exp_instr)
      else report_mismatch("i0_instr", $sampled(exp_instr), $sampled(i0_instr));
   a_cinst: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> i0_cinst == exp_instr[15:0])
      else report_mismatch("i0_cinst", $sampled(exp_instr[15:0]), $sampled(i0_cinst));
   a_pc: assert property (@(posedge clk) disable iff (reset) exp_valid |-> i0_pc == exp_pc)
      else report_mismatch("i0_pc", $sampled(exp_pc), $sampled(i0_pc));
   a_pc4: assert property (@(posedge clk) disable iff (reset) exp_valid |-> i0_pc4 == exp_pc4)
      else report_mismatch("i0_pc4", $sampled(exp_pc4), $sampled(i0_pc4));
   a_icaf: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> i0_icaf == exp_icaf)
      else report_mismatch("i0_icaf", $sampled(exp_icaf), $sampled(i0_icaf));
   a_type: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> i0_icaf_type == exp_type)
      else report_mismatch("i0_icaf_type", $sampled(exp_type), $sampled(i0_icaf_type));
   a_second: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> i0_icaf_second == exp_second)
      else report_mismatch("i0_icaf_second", $sampled(exp_second), $sampled(i0_icaf_second));
   a_dbecc: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> i0_dbecc == exp_dbecc)
      else report_mismatch("i0_dbecc", $sampled(exp_dbecc), $sampled(i0_dbecc));
   a_c1: assert property (@(posedge clk) disable iff (reset) consume1 == exp_c1)
      else report_mismatch("consume1", $sampled(exp_c1), $sampled(consume1));
   a_c2: assert property (@(posedge clk) disable iff (reset) consume2 == exp_c2)
      else report_mismatch("consume2", $sampled(exp_c2), $sampled(consume2));
   a_aligned: assert property (@(posedge clk) disable iff (reset)
      instr_aligned == (decode && !stall_m))
      else report_mismatch("instr_aligned", $sampled(decode && !stall_m),
                           $sampled(instr_aligned));

   //************************************************************
   // stimulus helpers
   //************************************************************
   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   function automatic logic [15:0] rand_half(bit wide);
      logic [15:0] h;
      h      = 16'($urandom);
      h[1:0] = wide ? 2'b11 : 2'($urandom % 3);
      return h;
   endfunction

   task automatic send_fetch(logic [31:0] data, logic [1:0] val, logic [1:0] icaf,
                             logic [1:0] ftype, logic [1:0] dbecc);
      int n;
      n = 0;
      while (occ >= 3 && hung == 0) begin   // no room until a consume frees an entry
         tick();
         n++;
         if (n > WAIT_MAX) begin
            hung = 1;
            $display("timeout: fetch buffer never had room");
         end
      end
      fetch_data        = data;
      fetch_pc          = next_pc;
      fetch_val         = val;
      access_fault      = icaf;
      access_fault_type = ftype;
      ecc_double_err    = dbecc;
      tick();
      fetch_val      = 2'b00;
      access_fault   = 2'b00;
      ecc_double_err = 2'b00;
      next_pc        = next_pc + PC_MSB'(2);
   endtask

   task automatic decode_one();
      int n;
      n = 0;
      while (!i0_valid && hung == 0) begin
         tick();
         n++;
         if (n > WAIT_MAX) begin
            hung = 1;
            $display("timeout: instruction 0 never became valid");
         end
      end
      repeat ($urandom % 3) tick();   // decode gap
      decode = 1'b1;
      tick();
      decode = 1'b0;
   endtask

   task automatic close_test(string name);
      repeat (2) tick();
      if (err_count == errs_at_start && hung == 0) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, err_count - errs_at_start);
      end
      errs_at_start = err_count;
   endtask

   //************************************************************
   // tests
   //************************************************************
   task automatic full_word_fetches();
      repeat (4) begin
         send_fetch({16'($urandom), rand_half(1)}, 2'b11, 2'b00, 2'b00, 2'b00);
         decode_one();
      end
      repeat (3) send_fetch({16'($urandom), rand_half(1)}, 2'b11, 2'b00, 2'b00, 2'b00);
      repeat (3) decode_one();
      close_test("full 32-bit fetches");
   endtask

   task automatic compressed_pairs();
      repeat (3) begin
         send_fetch({rand_half(0), rand_half(0)}, 2'b11, 2'b00, 2'b00, 2'b00);
         repeat (2) decode_one();
      end
      close_test("compressed pairs");
   endtask

   task automatic straddled_instrs();
      send_fetch({rand_half(1), rand_half(0)}, 2'b11, 2'b00, 2'b00, 2'b00);
      decode_one();
      repeat (3) tick();   // upper half alone cannot issue
      send_fetch({rand_half(0), 16'($urandom)}, 2'b11, 2'b00, 2'b00, 2'b00);
      repeat (2) decode_one();
      // low halfword only fetch starting a 32-bit instruction
      send_fetch({16'($urandom), rand_half(1)}, 2'b01, 2'b00, 2'b00, 2'b00);
      repeat (2) tick();
      send_fetch({rand_half(0), 16'($urandom)}, 2'b11, 2'b00, 2'b00, 2'b00);
      repeat (2) decode_one();
      // both entries drain on one decode
      send_fetch({rand_half(1), rand_half(0)}, 2'b11, 2'b00, 2'b00, 2'b00);
      decode_one();
      send_fetch({16'($urandom), 16'($urandom)}, 2'b01, 2'b00, 2'b00, 2'b00);
      decode_one();
      close_test("straddling instructions");
   endtask

   task automatic fault_merging();
      send_fetch({rand_half(1), rand_half(0)}, 2'b11, 2'b00, 2'b01, 2'b00);
      decode_one();
      send_fetch({rand_half(0), 16'($urandom)}, 2'b11, 2'b01, 2'b10, 2'b00);
      repeat (2) decode_one();
      // second halfword also faults, first one keeps icaf_second low
      send_fetch({16'($urandom), rand_half(1)}, 2'b11, 2'b10, 2'b11, 2'b01);
      decode_one();
      close_test("fault flags");
   endtask

   task automatic flush_recovery();
      send_fetch({16'($urandom), rand_half(1)}, 2'b11, 2'b00, 2'b00, 2'b00);
      send_fetch({rand_half(1), rand_half(0)}, 2'b11, 2'b00, 2'b00, 2'b00);
      flush  = 1'b1;
      decode = 1'b1;   // nothing retires across the flush
      tick();
      flush = 1'b0;
      tick();
      decode = 1'b0;
      send_fetch({rand_half(0), rand_half(0)}, 2'b11, 2'b00, 2'b00, 2'b00);
      repeat (2) decode_one();
      close_test("flush");
   endtask

   task automatic error_stall_hold();
      send_fetch({rand_half(0), rand_half(0)}, 2'b11, 2'b00, 2'b00, 2'b00);
      async_error_start = 1'b1;
      tick();
      async_error_start = 1'b0;
      decode = 1'b1;   // held off by the stall
      repeat (3) tick();
      decode = 1'b0;
      flush  = 1'b1;
      tick();
      flush  = 1'b0;
      send_fetch({rand_half(0), rand_half(0)}, 2'b11, 2'b00, 2'b00, 2'b00);
      repeat (2) decode_one();
      close_test("error stall");
   endtask

   initial begin
      void'($urandom(95));
      reset             = 1'b1;
      decode            = 1'b0;
      flush             = 1'b0;
      async_error_start = 1'b0;
      fetch_data        = '0;
      fetch_pc          = '0;
      fetch_val         = 2'b00;
      access_fault      = 2'b00;
      access_fault_type = 2'b00;
      ecc_double_err    = 2'b00;
      next_pc           = PC_MSB'('h100);
      err_count         = 0;
      errs_at_start     = 0;
      hung              = 0;
      tests_passed      = 0;
      tests_failed      = 0;
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;
      tick();
      full_word_fetches();
      compressed_pairs();
      straddled_instrs();
      fault_merging();
      flush_recovery();
      error_stall_hold();
      $display("tests passed %0d failed %0d, check errors %0d",
               tests_passed, tests_failed, err_count);
      if (tests_failed == 0 && err_count == 0 && hung == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- verilog.f
logic/ifu_align_pkg.sv
logic/align_slot_ctl.sv
logic/fetch_queue_ptr.sv
logic/fetch_queue_store.sv
logic/instr_align_out.sv
logic/ifu_align_top.sv
test/tb_ifu_align.sv

//--- Makefile
# Verilator build and run of the instruction aligner testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_ifu_align -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_ifu_align | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "no result in sim.log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) sim.log
